/* fe_top.f */
source/fe_pkg.sv
source/fe_pc_gen.sv
source/fe_itlb.sv
source/fe_fetch.sv
source/fe_queue_buf.sv
source/fe_top.sv
bench/fe_top_chk.sv
bench/fe_top_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module fe_top_tb \
   -f fe_top.f \
   -o fe_top_sim

output="$(./obj_dir/fe_top_sim +verilator+error+limit+100)"
echo "$output"

if grep -qx "Verification passed" <<< "$output"; then
   exit 0
fi
exit 1

/* bench/fe_top_tb.sv */
module fe_top_tb
   import fe_pkg::*;
();

   localparam int                    num_msgs   = 3000;
   localparam int                    cyc_limit  = 40;
   localparam int                    clk_period = 4;
   localparam logic [31:0]           seed_init  = 32'h7501;
   localparam logic [vtag_width-1:0] page_base  = 20'h40000;

   logic                   clk_i;
   logic                   rst_n_i;
   fe_cmd_s                fe_cmd_i;
   logic                   fe_cmd_v_i;
   logic                   fe_cmd_ready_o;
   fe_imem_req_s           imem_req_o;
   logic                   imem_req_v_o;
   logic                   imem_req_ready_i;
   logic [instr_width-1:0] imem_resp_i;
   logic                   imem_resp_v_i;
   fe_queue_s              fe_queue_o;
   logic                   fe_queue_v_o;
   logic                   fe_queue_ready_i;

   logic [31:0]            seed;
   logic                   started;
   logic                   pending_miss;
   logic                   reset_check;
   logic [vaddr_width-1:0] exp_pc;
   logic [itlb_els-1:0]    m_valid;
   logic [vtag_width-1:0]  m_vtag [itlb_els];
   logic [1:0]             m_rr;
   logic                   mem_busy;
   int                     mem_wait;
   logic [paddr_width-1:0] mem_addr;

   int                     msg_count;
   int                     mismatches;
   int                     other_errors;
   int                     evictions;
   int                     redirects;
   int                     reset_misses;
   string                  test_name;

   fe_top dut (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .fe_cmd_i         (fe_cmd_i),
      .fe_cmd_v_i       (fe_cmd_v_i),
      .fe_cmd_ready_o   (fe_cmd_ready_o),
      .imem_req_o       (imem_req_o),
      .imem_req_v_o     (imem_req_v_o),
      .imem_req_ready_i (imem_req_ready_i),
      .imem_resp_i      (imem_resp_i),
      .imem_resp_v_i    (imem_resp_v_i),
      .fe_queue_o       (fe_queue_o),
      .fe_queue_v_o     (fe_queue_v_o),
      .fe_queue_ready_i (fe_queue_ready_i)
   );

   initial
   begin
      clk_i = 1'b0;
      forever
         #(clk_period / 2) clk_i = ~clk_i;
   end

   function automatic logic [31:0] rand_next();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed ^ (seed >> 15);
   endfunction

   // fixed page map and memory contents
   function automatic logic [ptag_width-1:0] page_map(input logic [vtag_width-1:0] vtag);
      return {vtag[7:0], vtag[19:8]} ^ 20'h2c5a3;
   endfunction

   function automatic logic [instr_width-1:0] mem_word(input logic [paddr_width-1:0] paddr);
      logic [31:0] x;
      x = paddr * 32'h9e3779b1;
      return x ^ (x >> 16) ^ {paddr[15:0], paddr[31:16]};
   endfunction

   function automatic int mirror_find(input logic [vtag_width-1:0] vtag);
      for (int i = 0; i < itlb_els; i++)
      begin
         if (m_valid[i] && m_vtag[i] == vtag)
            return i;
      end
      return -1;
   endfunction

   task automatic check_msg(input fe_queue_s got);
      fe_msg_type_e           exp_type;
      logic [instr_width-1:0] exp_instr;
      logic [vtag_width-1:0]  vt;
      int                     idx;
      msg_count++;
      if (!started || pending_miss)
      begin
         other_errors++;
         $display("error: message at pc %h while the front end should be idle", got.pc);
         return;
      end
      vt        = exp_pc[vaddr_width-1:page_offset_width];
      idx       = mirror_find(vt);
      exp_type  = (idx < 0) ? msg_itlb_miss : msg_fetch;
      exp_instr = (idx < 0) ? '0 : mem_word({page_map(vt), exp_pc[page_offset_width-1:0]});
      if (got.msg_type != exp_type)
      begin
         mismatches++;
         $display("mismatch %s msg_type: expected %0d, actual %0d", test_name, exp_type,
                  got.msg_type);
      end
      if (got.pc != exp_pc)
      begin
         mismatches++;
         $display("mismatch %s pc: expected %h, actual %h", test_name, exp_pc, got.pc);
      end
      if (got.instr != exp_instr)
      begin
         mismatches++;
         $display("mismatch %s instr: expected %h, actual %h", test_name, exp_instr, got.instr);
      end
      if (reset_check && got.msg_type == msg_itlb_miss)
         reset_misses++;
      reset_check = 1'b0;
      if (idx < 0)
         pending_miss = 1'b1;
      else
         exp_pc = exp_pc + 32'd4;
   endtask

   task automatic apply_cmd(input fe_cmd_s cmd);
      logic [vaddr_width-1:0] pc;
      pc = cmd.operands.pc_op.pc;
      pending_miss = 1'b0;
      case (cmd.opcode)
         op_state_reset:
         begin
            // page known before the reset must miss afterwards
            reset_check = (mirror_find(pc[vaddr_width-1:page_offset_width]) >= 0);
            started     = 1'b1;
            exp_pc      = pc;
            m_valid     = '0;
            m_rr        = 2'd0;
            test_name   = "state_reset";
         end
         op_pc_redirect:
         begin
            reset_check = 1'b0;
            exp_pc      = pc;
            redirects++;
            test_name   = "redirect";
         end
         op_itlb_fill:
         begin
            if (m_valid[m_rr])
               evictions++;
            m_valid[m_rr] = 1'b1;
            m_vtag[m_rr]  = cmd.operands.fill_op.vtag;
            m_rr          = m_rr + 2'd1;
            test_name     = "itlb_fill";
         end
         default:
         begin
            other_errors++;
            $display("error: unknown opcode sent by the testbench");
         end
      endcase
   endtask

   task automatic drive_cmd();
      logic [31:0]            r;
      logic [31:0]            pick;
      logic [vtag_width-1:0]  vt;
      logic [vaddr_width-1:0] target;
      r          = rand_next();
      pick       = rand_next();
      vt         = page_base + vtag_width'(r[7:0] % 8'd6);
      target     = {vt, r[17:8], 2'b00};
      fe_cmd_v_i = 1'b0;
      fe_cmd_i   = '0;
      // some targets sit near a page end
      if (r[21])
         target[11:6] = 6'h3f;
      if (!fe_cmd_ready_o)
         return;
      if (!started || pick[31:20] < 12'd5)
      begin
         fe_cmd_v_i                  = 1'b1;
         fe_cmd_i.opcode             = op_state_reset;
         fe_cmd_i.operands.pc_op.pc  = started ? exp_pc : target;
      end
      else if (pending_miss && pick[7:6] == 2'b00)
      begin
         vt                            = exp_pc[vaddr_width-1:page_offset_width];
         fe_cmd_v_i                    = 1'b1;
         fe_cmd_i.opcode               = op_itlb_fill;
         fe_cmd_i.operands.fill_op.vtag = vt;
         fe_cmd_i.operands.fill_op.ptag = page_map(vt);
      end
      else if (pick[15:8] < 8'd4)
      begin
         fe_cmd_v_i                 = 1'b1;
         fe_cmd_i.opcode            = op_pc_redirect;
         fe_cmd_i.operands.pc_op.pc = target;
      end
   endtask

   // one response per request after 1 to 4 cycles
   task automatic drive_memory();
      logic [31:0] r;
      r             = rand_next();
      imem_resp_v_i = 1'b0;
      if (mem_busy)
      begin
         if (mem_wait == 0)
         begin
            imem_resp_v_i = 1'b1;
            imem_resp_i   = mem_word(mem_addr);
            mem_busy      = 1'b0;
         end
         else
            mem_wait--;
      end
      imem_req_ready_i = r[0] & ~mem_busy;
      if (imem_req_v_o && imem_req_ready_i)
      begin
         mem_busy = 1'b1;
         mem_addr = imem_req_o.paddr;
         mem_wait = int'(r[9:8]);
      end
   endtask

   initial
   begin
      #(num_msgs * cyc_limit * clk_period);
      $display("error: watchdog timeout after %0d of %0d messages", msg_count, num_msgs);
      $display("Verification failed");
      $finish;
   end

   initial
   begin
      logic [31:0] r;
      seed             = seed_init;
      rst_n_i          = 1'b0;
      fe_cmd_i         = '0;
      fe_cmd_v_i       = 1'b0;
      imem_req_ready_i = 1'b0;
      imem_resp_i      = '0;
      imem_resp_v_i    = 1'b0;
      fe_queue_ready_i = 1'b0;
      started          = 1'b0;
      pending_miss     = 1'b0;
      reset_check      = 1'b0;
      exp_pc           = '0;
      m_valid          = '0;
      m_rr             = 2'd0;
      mem_busy         = 1'b0;
      mem_wait         = 0;
      mem_addr         = '0;
      msg_count        = 0;
      mismatches       = 0;
      other_errors     = 0;
      evictions        = 0;
      redirects        = 0;
      reset_misses     = 0;
      test_name        = "idle";
      repeat (10)
      begin
         @(negedge clk_i);
         if (fe_cmd_ready_o || fe_queue_v_o || imem_req_v_o)
         begin
            other_errors++;
            $display("error: ready or valid output high while in reset");
         end
      end
      rst_n_i = 1'b1;

      while (msg_count < num_msgs)
      begin
         @(negedge clk_i);
         if (!fe_cmd_ready_o)
         begin
            other_errors++;
            $display("error: command port not ready after reset");
         end
         drive_cmd();
         r                = rand_next();
         fe_queue_ready_i = (r[1:0] != 2'b00);
         drive_memory();
         // a message transferring at the coming edge is older than the command
         if (fe_queue_v_o && fe_queue_ready_i)
            check_msg(fe_queue_o);
         if (fe_cmd_v_i && fe_cmd_ready_o)
            apply_cmd(fe_cmd_i);
      end

      if (evictions == 0)
      begin
         other_errors++;
         $display("error: no itlb entry was ever replaced");
      end
      if (redirects == 0)
      begin
         other_errors++;
         $display("error: no redirect was sent");
      end
      if (reset_misses == 0)
      begin
         other_errors++;
         $display("error: no mid-stream state reset was followed by a miss on a known page");
      end
      $display("errors: %0d mismatches, %0d other, %0d assertion failures over %0d messages",
               mismatches, other_errors, dut.chk.fail_count, msg_count);
      if (mismatches + other_errors + dut.chk.fail_count == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

/* bench/fe_top_chk.sv */
module fe_top_chk
   import fe_pkg::*;
(
   input logic         clk_i,
   input logic         rst_n_i,
   input logic         flush_i,
   input fe_imem_req_s imem_req_i,
   input logic         imem_req_v_i,
   input logic         imem_req_ready_i,
   input logic         imem_resp_v_i,
   input fe_queue_s    fe_queue_i,
   input logic         fe_queue_v_i,
   input logic         fe_queue_ready_i
);

   int   fail_count = 0;
   logic outstanding_r;

   // one memory request between request and response
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
         outstanding_r <= 1'b0;
      else if (imem_req_v_i && imem_req_ready_i)
         outstanding_r <= 1'b1;
      else if (imem_resp_v_i)
         outstanding_r <= 1'b0;
   end

   req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      imem_req_v_i && !imem_req_ready_i |=> imem_req_v_i && $stable(imem_req_i))
   else
   begin
      $error("imem request changed or dropped before it was accepted");
      fail_count++;
   end

   // a flush may empty the buffer without a transfer
   queue_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      fe_queue_v_i && !fe_queue_ready_i && !flush_i |=> fe_queue_v_i && $stable(fe_queue_i))
   else
   begin
      $error("output message changed or dropped while stalled by the consumer");
      fail_count++;
   end

   single_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      imem_req_v_i |-> !outstanding_r)
   else
   begin
      $error("second imem request issued before the response");
      fail_count++;
   end

endmodule

bind fe_top fe_top_chk chk (
   .clk_i            (clk_i),
   .rst_n_i          (rst_n_i),
   .flush_i          (flush),
   .imem_req_i       (imem_req_o),
   .imem_req_v_i     (imem_req_v_o),
   .imem_req_ready_i (imem_req_ready_i),
   .imem_resp_v_i    (imem_resp_v_i),
   .fe_queue_i       (fe_queue_o),
   .fe_queue_v_i     (fe_queue_v_o),
   .fe_queue_ready_i (fe_queue_ready_i)
);

/* source/fe_top.sv */
module fe_top
   import fe_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rst_n_i,

   input  fe_cmd_s                fe_cmd_i,
   input  logic                   fe_cmd_v_i,
   output logic                   fe_cmd_ready_o,

   output fe_imem_req_s           imem_req_o,
   output logic                   imem_req_v_o,
   input  logic                   imem_req_ready_i,

   input  logic [instr_width-1:0] imem_resp_i,
   input  logic                   imem_resp_v_i,

   output fe_queue_s              fe_queue_o,
   output logic                   fe_queue_v_o,
   input  logic                   fe_queue_ready_i
);

   fe_lookup_s            lookup;
   logic                  lookup_v;
   logic                  flush;
   logic                  itlb_clear;
   logic                  fill_v;
   logic [vtag_width-1:0] fill_vtag;
   logic [ptag_width-1:0] fill_ptag;
   fe_xlate_s             xlate;
   logic                  xlate_v;
   logic                  miss;
   logic                  done;
   fe_queue_s             msg;
   logic                  msg_v;
   logic                  msg_ready;

   // input side
   fe_pc_gen pc_gen (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .fe_cmd_i       (fe_cmd_i),
      .fe_cmd_v_i     (fe_cmd_v_i),
      .fe_cmd_ready_o (fe_cmd_ready_o),
      .miss_i         (miss),
      .done_i         (done),
      .lookup_o       (lookup),
      .lookup_v_o     (lookup_v),
      .flush_o        (flush),
      .itlb_clear_o   (itlb_clear),
      .fill_v_o       (fill_v),
      .fill_vtag_o    (fill_vtag),
      .fill_ptag_o    (fill_ptag)
   );

   fe_itlb itlb (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .clear_i     (itlb_clear),
      .lookup_i    (lookup),
      .lookup_v_i  (lookup_v),
      .fill_v_i    (fill_v),
      .fill_vtag_i (fill_vtag),
      .fill_ptag_i (fill_ptag),
      .flush_i     (flush),
      .xlate_o     (xlate),
      .xlate_v_o   (xlate_v)
   );

   fe_fetch fetch (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .xlate_i          (xlate),
      .xlate_v_i        (xlate_v),
      .flush_i          (flush),
      .imem_req_o       (imem_req_o),
      .imem_req_v_o     (imem_req_v_o),
      .imem_req_ready_i (imem_req_ready_i),
      .imem_resp_i      (imem_resp_i),
      .imem_resp_v_i    (imem_resp_v_i),
      .msg_o            (msg),
      .msg_v_o          (msg_v),
      .msg_ready_i      (msg_ready),
      .miss_o           (miss),
      .done_o           (done)
   );

   // output side
   fe_queue_buf queue_buf (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .flush_i          (flush),
      .msg_i            (msg),
      .msg_v_i          (msg_v),
      .msg_ready_o      (msg_ready),
      .fe_queue_o       (fe_queue_o),
      .fe_queue_v_o     (fe_queue_v_o),
      .fe_queue_ready_i (fe_queue_ready_i)
   );

endmodule

/* source/fe_queue_buf.sv */
module fe_queue_buf
   import fe_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n_i,

   input  logic      flush_i,

   input  fe_queue_s msg_i,
   input  logic      msg_v_i,
   output logic      msg_ready_o,

   output fe_queue_s fe_queue_o,
   output logic      fe_queue_v_o,
   input  logic      fe_queue_ready_i
);

   fe_queue_s  mem_r [2];
   logic       wr_ptr_r;
   logic       rd_ptr_r;
   logic [1:0] count_r;

   logic       push;
   logic       pop;

   assign msg_ready_o  = (count_r != 2'd2);
   assign fe_queue_v_o = (count_r != 2'd0);
   assign fe_queue_o   = mem_r[rd_ptr_r];

   // pushes in a flush cycle belong to the old stream
   assign push = msg_v_i & msg_ready_o & ~flush_i;
   assign pop  = fe_queue_v_o & fe_queue_ready_i;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i || flush_i)
      begin
         wr_ptr_r <= 1'b0;
         rd_ptr_r <= 1'b0;
         count_r  <= 2'd0;
      end
      else
      begin
         if (push)
            wr_ptr_r <= ~wr_ptr_r;
         if (pop)
            rd_ptr_r <= ~rd_ptr_r;
         if (push && !pop)
            count_r <= count_r + 2'd1;
         else if (pop && !push)
            count_r <= count_r - 2'd1;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (push)
         mem_r[wr_ptr_r] <= msg_i;
   end

endmodule

/* source/fe_fetch.sv */
module fe_fetch
   import fe_pkg::*;
(
   input  logic                   clk_i,
   input  logic                   rst_n_i,

   input  fe_xlate_s              xlate_i,
   input  logic                   xlate_v_i,

   input  logic                   flush_i,

   output fe_imem_req_s           imem_req_o,
   output logic                   imem_req_v_o,
   input  logic                   imem_req_ready_i,

   input  logic [instr_width-1:0] imem_resp_i,
   input  logic                   imem_resp_v_i,

   output fe_queue_s              msg_o,
   output logic                   msg_v_o,
   input  logic                   msg_ready_i,

   output logic                   miss_o,
   output logic                   done_o
);

   fe_xlate_s              xlate_r;
   logic                   xlate_pend_r;
   fe_imem_req_s           req_r;
   logic [vaddr_width-1:0] req_pc_r;
   logic                   req_v_r;
   logic                   wait_r;
   logic                   poison_r;
   fe_queue_s              msg_r;
   logic                   msg_v_r;

   logic                   busy;
   logic                   start;
   logic                   resp_keep;
   logic                   push;

   assign busy      = req_v_r | wait_r | msg_v_r;
   // a flushed translation never starts a request
   assign start     = xlate_pend_r & ~busy & ~flush_i;
   assign resp_keep = wait_r & imem_resp_v_i & ~poison_r;
   assign push      = msg_v_r & msg_ready_i;

   assign imem_req_o   = req_r;
   assign imem_req_v_o = req_v_r;
   assign msg_o        = msg_r;
   assign msg_v_o      = msg_v_r;
   assign miss_o       = push & (msg_r.msg_type == msg_itlb_miss);
   assign done_o       = push & (msg_r.msg_type == msg_fetch);

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         xlate_pend_r <= 1'b0;
         req_v_r      <= 1'b0;
         wait_r       <= 1'b0;
         poison_r     <= 1'b0;
         msg_v_r      <= 1'b0;
      end
      else
      begin
         if (req_v_r && imem_req_ready_i)
         begin
            req_v_r <= 1'b0;
            wait_r  <= 1'b1;
         end
         if (wait_r && imem_resp_v_i)
         begin
            wait_r   <= 1'b0;
            poison_r <= 1'b0;
         end
         if (push)
            msg_v_r <= 1'b0;
         if (xlate_v_i)
            xlate_pend_r <= 1'b1;
         if (start)
         begin
            xlate_pend_r <= 1'b0;
            if (xlate_r.miss)
               msg_v_r <= 1'b1;
            else
               req_v_r <= 1'b1;
         end
         if (resp_keep)
            msg_v_r <= 1'b1;
         // a request still at memory has its response dropped later
         if (flush_i)
         begin
            xlate_pend_r <= 1'b0;
            msg_v_r      <= 1'b0;
            if (req_v_r || (wait_r && !imem_resp_v_i))
               poison_r <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (xlate_v_i)
         xlate_r <= xlate_i;
      if (start)
      begin
         req_r.paddr <= {xlate_r.ptag, xlate_r.pc[page_offset_width-1:0]};
         req_pc_r    <= xlate_r.pc;
         if (xlate_r.miss)
            msg_r <= '{msg_type: msg_itlb_miss, pc: xlate_r.pc, instr: '0};
      end
      if (resp_keep)
         msg_r <= '{msg_type: msg_fetch, pc: req_pc_r, instr: imem_resp_i};
   end

endmodule

/* source/fe_itlb.sv */
module fe_itlb
   import fe_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,

   input  logic                  clear_i,

   input  fe_lookup_s            lookup_i,
   input  logic                  lookup_v_i,

   input  logic                  fill_v_i,
   input  logic [vtag_width-1:0] fill_vtag_i,
   input  logic [ptag_width-1:0] fill_ptag_i,

   input  logic                  flush_i,

   output fe_xlate_s             xlate_o,
   output logic                  xlate_v_o
);

   logic [itlb_els-1:0]         valid_r;
   logic [vtag_width-1:0]       vtag_r [itlb_els];
   logic [ptag_width-1:0]       ptag_r [itlb_els];
   logic [$clog2(itlb_els)-1:0] rr_r;

   fe_xlate_s                   xlate_r;
   logic                        xlate_v_r;

   logic                        hit;
   logic [ptag_width-1:0]       hit_ptag;

   // walk downward so the lowest matching index is the one kept
   always_comb
   begin
      hit      = 1'b0;
      hit_ptag = '0;
      for (int i = itlb_els - 1; i >= 0; i--)
      begin
         if (valid_r[i] && (vtag_r[i] == lookup_i.pc[vaddr_width-1:page_offset_width]))
         begin
            hit      = 1'b1;
            hit_ptag = ptag_r[i];
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         valid_r   <= '0;
         rr_r      <= '0;
         xlate_v_r <= 1'b0;
      end
      else
      begin
         xlate_v_r <= lookup_v_i & ~flush_i;
         if (clear_i)
         begin
            valid_r <= '0;
            rr_r    <= '0;
         end
         else if (fill_v_i)
         begin
            valid_r[rr_r] <= 1'b1;
            rr_r          <= rr_r + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (fill_v_i)
      begin
         vtag_r[rr_r] <= fill_vtag_i;
         ptag_r[rr_r] <= fill_ptag_i;
      end
      if (lookup_v_i)
      begin
         xlate_r.pc   <= lookup_i.pc;
         xlate_r.ptag <= hit_ptag;
         xlate_r.miss <= ~hit;
      end
   end

   assign xlate_o   = xlate_r;
   assign xlate_v_o = xlate_v_r;

endmodule

/* source/fe_pc_gen.sv */
module fe_pc_gen
   import fe_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_n_i,

   input  fe_cmd_s               fe_cmd_i,
   input  logic                  fe_cmd_v_i,
   output logic                  fe_cmd_ready_o,

   input  logic                  miss_i,
   input  logic                  done_i,

   output fe_lookup_s            lookup_o,
   output logic                  lookup_v_o,

   output logic                  flush_o,
   output logic                  itlb_clear_o,
   output logic                  fill_v_o,
   output logic [vtag_width-1:0] fill_vtag_o,
   output logic [ptag_width-1:0] fill_ptag_o
);

   logic                   ready_r;
   logic                   running_r;
   logic                   stalled_r;
   logic                   outstanding_r;
   logic [vaddr_width-1:0] pc_r;

   logic                   cmd_fire;
   logic                   is_reset;
   logic                   is_redirect;
   logic                   is_fill;

   assign fe_cmd_ready_o = ready_r;
   assign cmd_fire       = fe_cmd_v_i & ready_r;

   assign is_reset    = (fe_cmd_i.opcode == op_state_reset);
   assign is_redirect = (fe_cmd_i.opcode == op_pc_redirect);
   assign is_fill     = (fe_cmd_i.opcode == op_itlb_fill);

   // restart pulses, one cycle each
   assign flush_o      = cmd_fire & (is_reset | is_redirect);
   assign itlb_clear_o = cmd_fire & is_reset;

   assign fill_v_o    = cmd_fire & is_fill;
   assign fill_vtag_o = fe_cmd_i.operands.fill_op.vtag;
   assign fill_ptag_o = fe_cmd_i.operands.fill_op.ptag;

   // one lookup at a time, none while waiting on a fill
   assign lookup_v_o  = running_r & ~stalled_r & ~outstanding_r;
   assign lookup_o.pc = pc_r;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         ready_r       <= 1'b0;
         running_r     <= 1'b0;
         stalled_r     <= 1'b0;
         outstanding_r <= 1'b0;
      end
      else
      begin
         ready_r <= 1'b1;
         if (lookup_v_o)
            outstanding_r <= 1'b1;
         if (done_i)
            outstanding_r <= 1'b0;
         if (miss_i)
         begin
            outstanding_r <= 1'b0;
            stalled_r     <= 1'b1;
         end
         // retry of the same pc follows the fill
         if (fill_v_o)
            stalled_r <= 1'b0;
         if (flush_o)
         begin
            running_r     <= 1'b1;
            stalled_r     <= 1'b0;
            outstanding_r <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (flush_o)
         pc_r <= fe_cmd_i.operands.pc_op.pc;
      else if (done_i)
         pc_r <= pc_r + vaddr_width'(4);
   end

endmodule

/* source/fe_pkg.sv */
package fe_pkg;

   localparam int vaddr_width       = 32;
   localparam int paddr_width       = 32;
   localparam int page_offset_width = 12;
   localparam int vtag_width        = vaddr_width - page_offset_width;
   localparam int ptag_width        = paddr_width - page_offset_width;
   localparam int instr_width       = 32;
   localparam int itlb_els          = 4;

   typedef enum logic [1:0] {
      op_state_reset = 2'd0,
      op_pc_redirect = 2'd1,
      op_itlb_fill   = 2'd2
   } fe_opcode_e;

   // operand word seen as a pc
   typedef struct packed {
      logic [7:0]             pad;
      logic [vaddr_width-1:0] pc;
   } fe_pc_operands_s;

   // operand word seen as a translation
   typedef struct packed {
      logic [vtag_width-1:0] vtag;
      logic [ptag_width-1:0] ptag;
   } fe_fill_operands_s;

   typedef union packed {
      fe_pc_operands_s   pc_op;
      fe_fill_operands_s fill_op;
   } fe_cmd_operands_u;

   typedef struct packed {
      fe_opcode_e       opcode;
      fe_cmd_operands_u operands;
   } fe_cmd_s;

   typedef struct packed {
      logic [vaddr_width-1:0] pc;
   } fe_lookup_s;

   typedef struct packed {
      logic [vaddr_width-1:0] pc;
      logic [ptag_width-1:0]  ptag;
      logic                   miss;
   } fe_xlate_s;

   typedef struct packed {
      logic [paddr_width-1:0] paddr;
   } fe_imem_req_s;

   typedef enum logic {
      msg_fetch     = 1'b0,
      msg_itlb_miss = 1'b1
   } fe_msg_type_e;

   typedef struct packed {
      fe_msg_type_e           msg_type;
      logic [vaddr_width-1:0] pc;
      logic [instr_width-1:0] instr;
   } fe_queue_s;

endpackage
